//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module lsu_tb -o lsu_sim

out=$(./obj_dir/lsu_sim || true)
echo "$out"

# pass only when the testbench printed its pass line
echo "$out" | grep -q "^Test passed$"

//--- source/dbus_pkg.sv
package dbus_pkg;

	// bytes per data beat and the alignment of every bus address
	parameter int unsigned BEAT_BYTES = 8;

	typedef logic [63:0] beat_t;
	typedef logic [7:0]  strb_t;
	typedef logic [31:0] addr_t;

	// byte offset inside one beat
	typedef logic [2:0]  lane_t;

endpackage

//--- source/dbus_read_engine.sv
`timescale 1ns/100ps

module dbus_read_engine
	import dbus_pkg::*;
#(
	parameter int ID_WIDTH = 4
) (
	input  logic                clock,
	input  logic                reset,

	input  logic                read_start,
	input  addr_t               base_addr,
	input  logic                two_beats,

	output logic                dsram_arvalid,
	output addr_t               dsram_araddr,
	output logic [ID_WIDTH-1:0] dsram_arid,
	input  logic                dsram_arready,
	output logic                dsram_rready,
	input  logic                dsram_rvalid,
	input  beat_t               dsram_rdata,
	input  logic [ID_WIDTH-1:0] dsram_rid,

	output beat_t               beat_lo,
	output beat_t               beat_hi,
	output logic                read_done
);

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ADDR,
		RD_RESP
	} rd_state_e;

	rd_state_e           state;
	logic                second;
	logic [ID_WIDTH-1:0] id_cnt;
	logic                r_match;

	// beats carrying another id are taken and dropped
	assign r_match = dsram_rvalid && dsram_rready && (dsram_rid == dsram_arid);

	always_ff @(posedge clock) begin
		if (reset) begin
			state         <= RD_IDLE;
			second        <= 1'b0;
			id_cnt        <= '0;
			dsram_arvalid <= 1'b0;
			dsram_rready  <= 1'b0;
			read_done     <= 1'b0;
		end else begin
			read_done <= 1'b0;
			case (state)
				RD_IDLE: begin
					if (read_start) begin
						dsram_arvalid <= 1'b1;
						second        <= 1'b0;
						state         <= RD_ADDR;
					end
				end
				RD_ADDR: begin
					if (dsram_arready) begin
						dsram_arvalid <= 1'b0;
						dsram_rready  <= 1'b1;
						id_cnt        <= id_cnt + 1'b1;
						state         <= RD_RESP;
					end
				end
				RD_RESP: begin
					if (r_match) begin
						dsram_rready <= 1'b0;
						if (two_beats && !second) begin
							// second pass at the next beat address
							second        <= 1'b1;
							dsram_arvalid <= 1'b1;
							state         <= RD_ADDR;
						end else begin
							read_done <= 1'b1;
							state     <= RD_IDLE;
						end
					end
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

	// address and id are loaded whenever a new ar is raised
	always_ff @(posedge clock) begin
		if (state == RD_IDLE && read_start) begin
			dsram_araddr <= base_addr;
			dsram_arid   <= id_cnt;
		end else if (state == RD_RESP && r_match && two_beats && !second) begin
			dsram_araddr <= base_addr + BEAT_BYTES;
			dsram_arid   <= id_cnt;
		end
	end

	always_ff @(posedge clock) begin
		if (r_match) begin
			if (second)
				beat_hi <= dsram_rdata;
			else
				beat_lo <= dsram_rdata;
		end
	end

endmodule

//--- source/dbus_write_engine.sv
`timescale 1ns/100ps

module dbus_write_engine
	import dbus_pkg::*;
#(
	parameter int ID_WIDTH = 4
) (
	input  logic                clock,
	input  logic                reset,

	input  logic                write_start,
	input  addr_t               base_addr,
	input  logic                two_beats,
	input  strb_t               strb_lo,
	input  strb_t               strb_hi,
	input  beat_t               store_beat,

	output logic                dsram_awvalid,
	output addr_t               dsram_awaddr,
	output logic [ID_WIDTH-1:0] dsram_awid,
	input  logic                dsram_awready,
	output logic                dsram_wvalid,
	output beat_t               dsram_wdata,
	output strb_t               dsram_wstrb,
	input  logic                dsram_wready,
	output logic                dsram_bready,
	input  logic                dsram_bvalid,
	input  logic [ID_WIDTH-1:0] dsram_bid,

	output logic                write_done
);

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_ADDR,
		WR_DATA,
		WR_RESP
	} wr_state_e;

	wr_state_e           state;
	logic                second;
	logic [ID_WIDTH-1:0] id_cnt;
	logic                b_match;
	logic                next_round;

	assign b_match    = dsram_bvalid && dsram_bready && (dsram_bid == dsram_awid);
	assign next_round = state == WR_RESP && b_match && two_beats && !second;

	always_ff @(posedge clock) begin
		if (reset) begin
			state         <= WR_IDLE;
			second        <= 1'b0;
			id_cnt        <= '0;
			dsram_awvalid <= 1'b0;
			dsram_wvalid  <= 1'b0;
			dsram_bready  <= 1'b0;
			write_done    <= 1'b0;
		end else begin
			write_done <= 1'b0;
			case (state)
				WR_IDLE: begin
					if (write_start) begin
						dsram_awvalid <= 1'b1;
						second        <= 1'b0;
						state         <= WR_ADDR;
					end
				end
				WR_ADDR: begin
					if (dsram_awready) begin
						dsram_awvalid <= 1'b0;
						dsram_wvalid  <= 1'b1;
						id_cnt        <= id_cnt + 1'b1;
						state         <= WR_DATA;
					end
				end
				WR_DATA: begin
					if (dsram_wready) begin
						dsram_wvalid <= 1'b0;
						dsram_bready <= 1'b1;
						state        <= WR_RESP;
					end
				end
				WR_RESP: begin
					if (b_match) begin
						dsram_bready <= 1'b0;
						if (next_round) begin
							second        <= 1'b1;
							dsram_awvalid <= 1'b1;
							state         <= WR_ADDR;
						end else begin
							write_done <= 1'b1;
							state      <= WR_IDLE;
						end
					end
				end
				default: state <= WR_IDLE;
			endcase
		end
	end

	// aw payload switches to the high address on the second round
	always_ff @(posedge clock) begin
		if (state == WR_IDLE && write_start) begin
			dsram_awaddr <= base_addr;
			dsram_awid   <= id_cnt;
		end else if (next_round) begin
			dsram_awaddr <= base_addr + BEAT_BYTES;
			dsram_awid   <= id_cnt;
		end
	end

	// same rotated beat in both rounds with only the strobe changing
	always_ff @(posedge clock) begin
		if (state == WR_ADDR && dsram_awready) begin
			dsram_wdata <= store_beat;
			dsram_wstrb <= second ? strb_hi : strb_lo;
		end
	end

endmodule

//--- source/load_align.sv
`timescale 1ns/100ps

module load_align
	import lsu_defs_pkg::*;
	import dbus_pkg::*;
(
	input  lsu_op_e held_op,
	input  lane_t   held_lane,
	input  beat_t   beat_lo,
	input  beat_t   beat_hi,
	output word_t   regfile_wdata
);

	logic [127:0] window;
	logic [127:0] shifted;
	word_t        raw;

	// 16-byte view where the high beat only matters for crossing loads
	assign window  = {beat_hi, beat_lo};
	assign shifted = window >> {held_lane, 3'b000};
	assign raw     = shifted[31:0];

	always_comb begin
		case (held_op)
			OP_LH:   regfile_wdata = {{16{raw[15]}}, raw[15:0]};
			OP_LHU:  regfile_wdata = {16'b0, raw[15:0]};
			OP_LB:   regfile_wdata = {{24{raw[7]}}, raw[7:0]};
			OP_LBU:  regfile_wdata = {24'b0, raw[7:0]};
			// lw and the don't-care case of stores
			default: regfile_wdata = raw;
		endcase
	end

endmodule

//--- source/lsu_defs_pkg.sv
package lsu_defs_pkg;

	// memory instruction kinds handled by the stage
	typedef enum logic [3:0] {
		OP_LW  = 4'd0,
		OP_LH  = 4'd1,
		OP_LHU = 4'd2,
		OP_LB  = 4'd3,
		OP_LBU = 4'd4,
		OP_SW  = 4'd5,
		OP_SH  = 4'd6,
		OP_SB  = 4'd7
	} lsu_op_e;

	typedef logic [4:0]  reg_idx_t;
	typedef logic [31:0] word_t;

	function automatic logic is_load_op(input lsu_op_e op);
		return op inside {OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU};
	endfunction

	function automatic logic is_store_op(input lsu_op_e op);
		return op inside {OP_SW, OP_SH, OP_SB};
	endfunction

	// access size in bytes
	function automatic logic [2:0] op_bytes(input lsu_op_e op);
		case (op)
			OP_LW, OP_SW: return 3'd4;
			OP_LH, OP_LHU, OP_SH: return 3'd2;
			default: return 3'd1;
		endcase
	endfunction

endpackage

//--- source/lsu_request_stage.sv
`timescale 1ns/100ps

module lsu_request_stage
	import lsu_defs_pkg::*;
	import dbus_pkg::*;
(
	input  logic     clock,
	input  logic     reset,

	input  logic     req_valid,
	input  lsu_op_e  req_op,
	input  addr_t    req_addr,
	input  word_t    req_store_data,
	input  reg_idx_t req_rd,
	output logic     req_ready,

	input  logic     read_done,
	input  logic     write_done,

	output logic     read_start,
	output logic     write_start,
	output addr_t    base_addr,
	output logic     two_beats,
	output strb_t    strb_lo,
	output strb_t    strb_hi,
	output beat_t    store_beat,
	output lsu_op_e  held_op,
	output lane_t    held_lane,

	output logic     retire_valid,
	output logic     regfile_wen,
	output reg_idx_t regfile_waddr
);

	logic   held_valid;
	logic   fresh;
	logic   accept;
	addr_t  held_addr;
	word_t  held_store_data;
	logic   [3:0] byte_mask;
	logic   [3:0] access_end;
	word_t  data_masked;
	logic   [15:0] strb_window;
	logic   [127:0] data_window;

	assign accept = req_valid && req_ready;

	// allow-in when empty or when the held instruction leaves this cycle
	assign req_ready = !held_valid || retire_valid;

	always_ff @(posedge clock) begin
		if (reset) begin
			held_valid <= 1'b0;
			fresh      <= 1'b0;
		end else begin
			fresh <= accept;
			if (req_ready)
				held_valid <= req_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			held_op         <= req_op;
			held_addr       <= req_addr;
			held_store_data <= req_store_data;
			regfile_waddr   <= req_rd;
		end
	end

	// one-cycle kick to the matching engine
	assign read_start  = fresh && is_load_op(held_op);
	assign write_start = fresh && is_store_op(held_op);

	assign held_lane = held_addr[2:0];
	assign base_addr = {held_addr[31:3], 3'b000};

	// crossing when offset plus size runs past the beat
	assign access_end = {1'b0, held_lane} + {1'b0, op_bytes(held_op)};
	assign two_beats  = access_end > 4'(BEAT_BYTES);

	always_comb begin
		case (op_bytes(held_op))
			3'd4: byte_mask = 4'b1111;
			3'd2: byte_mask = 4'b0011;
			default: byte_mask = 4'b0001;
		endcase
	end

	assign data_masked = held_store_data & {{8{byte_mask[3]}}, {8{byte_mask[2]}},
		{8{byte_mask[1]}}, {8{byte_mask[0]}}};

	// two-beat window with the spill into the next beat in the upper half
	assign strb_window = {12'b0, byte_mask} << held_lane;
	assign strb_lo     = strb_window[7:0];
	assign strb_hi     = strb_window[15:8];

	// folding the window gives lane (offset + i) mod 8
	assign data_window = {96'b0, data_masked} << {held_lane, 3'b000};
	assign store_beat  = data_window[63:0] | data_window[127:64];

	assign retire_valid = held_valid && (read_done || write_done);
	assign regfile_wen  = retire_valid && is_load_op(held_op);

endmodule

//--- source/lsu_top.sv
`timescale 1ns/100ps

module lsu_top
	import lsu_defs_pkg::*;
	import dbus_pkg::*;
#(
	parameter int ID_WIDTH = 4
) (
	input  logic                clock,
	input  logic                reset,

	input  logic                req_valid,
	input  lsu_op_e             req_op,
	input  addr_t               req_addr,
	input  word_t               req_store_data,
	input  reg_idx_t            req_rd,
	output logic                req_ready,

	output logic                dsram_arvalid,
	output addr_t               dsram_araddr,
	output logic [ID_WIDTH-1:0] dsram_arid,
	input  logic                dsram_arready,
	output logic                dsram_rready,
	input  logic                dsram_rvalid,
	input  beat_t               dsram_rdata,
	input  logic [ID_WIDTH-1:0] dsram_rid,

	output logic                dsram_awvalid,
	output addr_t               dsram_awaddr,
	output logic [ID_WIDTH-1:0] dsram_awid,
	input  logic                dsram_awready,
	output logic                dsram_wvalid,
	output beat_t               dsram_wdata,
	output strb_t               dsram_wstrb,
	input  logic                dsram_wready,
	output logic                dsram_bready,
	input  logic                dsram_bvalid,
	input  logic [ID_WIDTH-1:0] dsram_bid,

	output logic                retire_valid,
	output logic                regfile_wen,
	output reg_idx_t            regfile_waddr,
	output word_t               regfile_wdata
);

	logic    read_start;
	logic    write_start;
	logic    read_done;
	logic    write_done;
	addr_t   base_addr;
	logic    two_beats;
	strb_t   strb_lo;
	strb_t   strb_hi;
	beat_t   store_beat;
	lsu_op_e held_op;
	lane_t   held_lane;
	beat_t   beat_lo;
	beat_t   beat_hi;

	lsu_request_stage request_i (
		.clock          (clock),
		.reset          (reset),
		.req_valid      (req_valid),
		.req_op         (req_op),
		.req_addr       (req_addr),
		.req_store_data (req_store_data),
		.req_rd         (req_rd),
		.req_ready      (req_ready),
		.read_done      (read_done),
		.write_done     (write_done),
		.read_start     (read_start),
		.write_start    (write_start),
		.base_addr      (base_addr),
		.two_beats      (two_beats),
		.strb_lo        (strb_lo),
		.strb_hi        (strb_hi),
		.store_beat     (store_beat),
		.held_op        (held_op),
		.held_lane      (held_lane),
		.retire_valid   (retire_valid),
		.regfile_wen    (regfile_wen),
		.regfile_waddr  (regfile_waddr)
	);

	dbus_read_engine #(
		.ID_WIDTH (ID_WIDTH)
	) read_i (
		.clock         (clock),
		.reset         (reset),
		.read_start    (read_start),
		.base_addr     (base_addr),
		.two_beats     (two_beats),
		.dsram_arvalid (dsram_arvalid),
		.dsram_araddr  (dsram_araddr),
		.dsram_arid    (dsram_arid),
		.dsram_arready (dsram_arready),
		.dsram_rready  (dsram_rready),
		.dsram_rvalid  (dsram_rvalid),
		.dsram_rdata   (dsram_rdata),
		.dsram_rid     (dsram_rid),
		.beat_lo       (beat_lo),
		.beat_hi       (beat_hi),
		.read_done     (read_done)
	);

	dbus_write_engine #(
		.ID_WIDTH (ID_WIDTH)
	) write_i (
		.clock         (clock),
		.reset         (reset),
		.write_start   (write_start),
		.base_addr     (base_addr),
		.two_beats     (two_beats),
		.strb_lo       (strb_lo),
		.strb_hi       (strb_hi),
		.store_beat    (store_beat),
		.dsram_awvalid (dsram_awvalid),
		.dsram_awaddr  (dsram_awaddr),
		.dsram_awid    (dsram_awid),
		.dsram_awready (dsram_awready),
		.dsram_wvalid  (dsram_wvalid),
		.dsram_wdata   (dsram_wdata),
		.dsram_wstrb   (dsram_wstrb),
		.dsram_wready  (dsram_wready),
		.dsram_bready  (dsram_bready),
		.dsram_bvalid  (dsram_bvalid),
		.dsram_bid     (dsram_bid),
		.write_done    (write_done)
	);

	load_align align_i (
		.held_op       (held_op),
		.held_lane     (held_lane),
		.beat_lo       (beat_lo),
		.beat_hi       (beat_hi),
		.regfile_wdata (regfile_wdata)
	);

endmodule

//--- testbench/lsu_properties.sv
`timescale 1ns/100ps

module lsu_properties
	import dbus_pkg::*;
(
	input logic  clock,
	input logic  reset,
	input logic  dsram_arvalid,
	input logic  dsram_arready,
	input addr_t dsram_araddr,
	input logic  dsram_awvalid,
	input logic  dsram_awready,
	input addr_t dsram_awaddr,
	input logic  retire_valid
);

	// valid and address held while waiting for ready
	ar_stable: assert property (@(posedge clock) disable iff (reset)
		dsram_arvalid && !dsram_arready |=> dsram_arvalid && $stable(dsram_araddr))
		else $error("arvalid or araddr changed before arready");

	aw_stable: assert property (@(posedge clock) disable iff (reset)
		dsram_awvalid && !dsram_awready |=> dsram_awvalid && $stable(dsram_awaddr))
		else $error("awvalid or awaddr changed before awready");

	ar_aligned: assert property (@(posedge clock) disable iff (reset)
		dsram_arvalid |-> dsram_araddr[2:0] == 3'b000)
		else $error("araddr not 8-byte aligned");

	aw_aligned: assert property (@(posedge clock) disable iff (reset)
		dsram_awvalid |-> dsram_awaddr[2:0] == 3'b000)
		else $error("awaddr not 8-byte aligned");

	retire_pulse: assert property (@(posedge clock) disable iff (reset)
		retire_valid |=> !retire_valid)
		else $error("retire_valid high for more than one cycle");

endmodule

bind lsu_top lsu_properties props_i (.*);

//--- testbench/lsu_stim.txt
// columns: kind (0 lw,1 lh,2 lhu,3 lb,4 lbu,5 sw,6 sh,7 sb; f ends), address,
// store data, rd, expected load value
5 00000100 11223344 00 00000000
5 00000104 55667788 00 00000000
5 00000108 99aabbcc 00 00000000
5 0000010c ddeeff00 00 00000000
0 00000100 00000000 01 11223344
1 00000106 00000000 02 00005566
1 0000010a 00000000 03 ffff99aa
2 0000010a 00000000 04 000099aa
3 00000109 00000000 05 ffffffbb
4 00000109 00000000 06 000000bb
3 00000100 00000000 07 00000044
0 00000105 00000000 08 cc556677
0 00000106 00000000 09 bbcc5566
0 00000107 00000000 0a aabbcc55
1 00000107 00000000 0b ffffcc55
2 00000107 00000000 0c 0000cc55
5 0000010e cafef00d 00 00000000
0 0000010e 00000000 0d cafef00d
6 00000117 dead1234 00 00000000
2 00000117 00000000 0e 00001234
7 0000010d 777777a5 00 00000000
4 0000010d 00000000 0f 000000a5
0 0000010c 00000000 10 f00da500
1 00000110 00000000 1f ffffcafe
f 00000000 00000000 00 00000000

//--- testbench/lsu_tb.sv
`timescale 1ns/100ps

module lsu_tb
	import lsu_defs_pkg::*;
	import dbus_pkg::*;
();

	localparam int ID_WIDTH  = 4;
	localparam int MAX_OPS   = 64;
	localparam int MEM_BYTES = 1024;

	logic clock, reset, req_valid, req_ready;
	lsu_op_e req_op;
	addr_t req_addr, dsram_araddr, dsram_awaddr;
	word_t req_store_data, regfile_wdata;
	reg_idx_t req_rd, regfile_waddr;
	logic dsram_arvalid, dsram_arready, dsram_rready, dsram_rvalid;
	logic dsram_awvalid, dsram_awready, dsram_wvalid, dsram_wready;
	logic dsram_bready, dsram_bvalid, retire_valid, regfile_wen;
	logic [ID_WIDTH-1:0] dsram_arid, dsram_rid, dsram_awid, dsram_bid;
	beat_t dsram_rdata, dsram_wdata;
	strb_t dsram_wstrb;

	logic [7:0]  mem [0:MEM_BYTES-1];
	logic [31:0] stim [0:MAX_OPS*5-1];
	int n_ops = 0;
	int accepted = 0;
	int retired = 0;
	int ar_total = 0;
	int w_total = 0;
	int ar_base, w_base;
	lsu_op_e cur_op;
	addr_t cur_addr;
	word_t cur_data, cur_expect;
	reg_idx_t cur_rd;
	addr_t ar_q[$], aw_q[$];
	logic [ID_WIDTH-1:0] ar_id_q[$], aw_id_q[$], b_q[$];

	lsu_top #(.ID_WIDTH(ID_WIDTH)) dut_i (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic fail_run(string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_word(string name, word_t exp, word_t act);
		if (exp !== act)
			fail_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_strb(string name, strb_t exp, strb_t act);
		if (exp !== act)
			fail_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_addr(string name, addr_t exp, addr_t act);
		if (exp !== act)
			fail_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_beat(string name, beat_t exp, beat_t act);
		if (exp !== act)
			fail_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
	endtask

	function automatic int access_size(lsu_op_e op);
		case (op)
			OP_LW, OP_SW: return 4;
			OP_LH, OP_LHU, OP_SH: return 2;
			default: return 1;
		endcase
	endfunction

	function automatic logic load_kind(lsu_op_e op);
		return op == OP_LW || op == OP_LH || op == OP_LHU || op == OP_LB || op == OP_LBU;
	endfunction

	function automatic int beat_count(addr_t a, lsu_op_e op);
		return (int'(a[2:0]) + access_size(op) > 8) ? 2 : 1;
	endfunction

	// lanes a store touches in the given beat
	function automatic strb_t lane_strobe(addr_t a, lsu_op_e op, int beat);
		strb_t s;
		int lane;
		s = '0;
		for (int i = 0; i < access_size(op); i++) begin
			lane = int'(a[2:0]) + i;
			if (beat == 0 && lane < 8)
				s[lane] = 1'b1;
			else if (beat == 1 && lane >= 8)
				s[lane-8] = 1'b1;
		end
		return s;
	endfunction

	function automatic beat_t store_lanes(addr_t a, lsu_op_e op, word_t d);
		beat_t b;
		b = '0;
		for (int i = 0; i < access_size(op); i++)
			b[((int'(a[2:0]) + i) % 8)*8 +: 8] = d[i*8 +: 8];
		return b;
	endfunction

	function automatic beat_t strb_mask(strb_t s);
		beat_t m;
		for (int l = 0; l < 8; l++)
			m[l*8 +: 8] = {8{s[l]}};
		return m;
	endfunction

	function automatic beat_t read_beat(addr_t a);
		beat_t b;
		for (int i = 0; i < 8; i++)
			b[i*8 +: 8] = mem[(int'(a) + i) % MEM_BYTES];
		return b;
	endfunction

	initial begin
		int base;
		void'($urandom(86));
		reset = 1'b1;
		req_valid = 1'b0;
		req_op = OP_LW;
		req_addr = '0;
		req_store_data = '0;
		req_rd = '0;
		$readmemh("testbench/lsu_stim.txt", stim);
		while (n_ops < MAX_OPS && stim[n_ops*5] != 32'hf)
			n_ops++;
		repeat (16) @(posedge clock);
		#0.5 reset = 1'b0;
		repeat (3) begin
			@(negedge clock);
			if ({dsram_arvalid, dsram_rready, dsram_awvalid, dsram_wvalid, dsram_bready,
				retire_valid, regfile_wen} !== 7'b0)
				fail_run("a bus or retire output is active after reset with no request");
		end
		@(posedge clock);
		#0.5;
		for (int n = 0; n < n_ops; n++) begin
			base = n * 5;
			repeat ($urandom_range(0, 2)) begin
				@(posedge clock);
				#0.5;
			end
			req_valid = 1'b1;
			req_op = lsu_op_e'(stim[base][3:0]);
			req_addr = stim[base+1];
			req_store_data = stim[base+2];
			req_rd = stim[base+3][4:0];
			// valid stays up until the stage lets it in
			while (!req_ready) begin
				@(posedge clock);
				#0.5;
			end
			@(posedge clock);
			cur_op = req_op;
			cur_addr = req_addr;
			cur_data = req_store_data;
			cur_rd = req_rd;
			cur_expect = stim[base+4];
			ar_base = ar_total;
			w_base = w_total;
			accepted++;
			#0.5 req_valid = 1'b0;
		end
		while (retired != accepted)
			@(negedge clock);
		// idle time to expose a late retire or a stray bus request
		repeat (8) @(negedge clock);
		if ({dsram_arvalid, dsram_rready, dsram_awvalid, dsram_wvalid, dsram_bready}
			=== 5'b0) begin
			$display("Test passed");
			$finish;
		end else begin
			fail_run("bus still active after the last instruction retired");
		end
	end

	// retire monitor that also watches the allow-in and the write enable
	always @(negedge clock) begin
		if (!reset) begin
			check_word($sformatf("op %0d req_ready", accepted),
				32'(accepted == retired || retire_valid), 32'(req_ready));
			if (regfile_wen && !retire_valid)
				fail_run("regfile_wen is high outside a retire cycle");
		end
		if (!reset && retire_valid) begin
			if (retired >= accepted)
				fail_run("retire_valid seen with no instruction in flight");
			retired++;
			check_word($sformatf("op %0d regfile_wen", retired), 32'(load_kind(cur_op)),
				32'(regfile_wen));
			if (load_kind(cur_op)) begin
				check_word($sformatf("op %0d regfile_waddr", retired), 32'(cur_rd),
					32'(regfile_waddr));
				check_word($sformatf("op %0d load value", retired), cur_expect, regfile_wdata);
				check_word($sformatf("op %0d ar count", retired),
					32'(beat_count(cur_addr, cur_op)), 32'(ar_total - ar_base));
				check_word($sformatf("op %0d w count", retired), 32'd0,
					32'(w_total - w_base));
			end else begin
				check_word($sformatf("op %0d w count", retired),
					32'(beat_count(cur_addr, cur_op)), 32'(w_total - w_base));
				check_word($sformatf("op %0d ar count", retired), 32'd0,
					32'(ar_total - ar_base));
			end
		end
	end

	initial begin
		dsram_arready = 1'b0;
		forever begin
			@(negedge clock);
			if (dsram_arvalid) begin
				check_addr($sformatf("op %0d araddr", accepted),
					{cur_addr[31:3], 3'b000} + 32'(8 * (ar_total - ar_base)), dsram_araddr);
				ar_q.push_back(dsram_araddr);
				ar_id_q.push_back(dsram_arid);
				repeat ($urandom_range(0, 3)) @(posedge clock);
				@(posedge clock);
				#0.5 dsram_arready = 1'b1;
				@(posedge clock);
				ar_total++;
				#0.5 dsram_arready = 1'b0;
			end
		end
	end

	initial begin
		dsram_rvalid = 1'b0;
		dsram_rdata = '0;
		dsram_rid = '0;
		forever begin
			@(negedge clock);
			if (ar_q.size() != 0) begin
				repeat ($urandom_range(0, 3)) @(posedge clock);
				@(posedge clock);
				#0.5;
				dsram_rvalid = 1'b1;
				dsram_rid = ar_id_q[0];
				dsram_rdata = read_beat(ar_q[0]);
				do @(negedge clock); while (!dsram_rready);
				@(posedge clock);
				#0.5 dsram_rvalid = 1'b0;
				void'(ar_q.pop_front());
				void'(ar_id_q.pop_front());
			end
		end
	end

	initial begin
		dsram_awready = 1'b0;
		forever begin
			@(negedge clock);
			if (dsram_awvalid) begin
				check_addr($sformatf("op %0d awaddr", accepted),
					{cur_addr[31:3], 3'b000} + 32'(8 * (w_total - w_base)), dsram_awaddr);
				aw_q.push_back(dsram_awaddr);
				aw_id_q.push_back(dsram_awid);
				repeat ($urandom_range(0, 3)) @(posedge clock);
				@(posedge clock);
				#0.5 dsram_awready = 1'b1;
				@(posedge clock);
				#0.5 dsram_awready = 1'b0;
			end
		end
	end

	// write data channel owns the memory contents too
	initial begin
		strb_t exp_strb;
		dsram_wready = 1'b0;
		for (int a = 0; a < MEM_BYTES; a++)
			mem[a] = 8'((a * 13) ^ (a >> 8) ^ 8'h5a);
		forever begin
			@(negedge clock);
			if (dsram_wvalid) begin
				exp_strb = lane_strobe(cur_addr, cur_op, w_total - w_base);
				check_strb($sformatf("op %0d wstrb", accepted), exp_strb, dsram_wstrb);
				check_beat($sformatf("op %0d wdata", accepted),
					store_lanes(cur_addr, cur_op, cur_data),
					dsram_wdata & strb_mask(lane_strobe(cur_addr, cur_op, 0)
						| lane_strobe(cur_addr, cur_op, 1)));
				repeat ($urandom_range(0, 3)) @(posedge clock);
				@(posedge clock);
				#0.5 dsram_wready = 1'b1;
				@(posedge clock);
				for (int l = 0; l < 8; l++)
					if (dsram_wstrb[l])
						mem[(int'(aw_q[0]) + l) % MEM_BYTES] = dsram_wdata[l*8 +: 8];
				w_total++;
				b_q.push_back(aw_id_q[0]);
				void'(aw_q.pop_front());
				void'(aw_id_q.pop_front());
				#0.5 dsram_wready = 1'b0;
			end
		end
	end

	initial begin
		dsram_bvalid = 1'b0;
		dsram_bid = '0;
		forever begin
			@(negedge clock);
			if (b_q.size() != 0) begin
				repeat ($urandom_range(0, 3)) @(posedge clock);
				@(posedge clock);
				#0.5;
				dsram_bvalid = 1'b1;
				dsram_bid = b_q[0];
				do @(negedge clock); while (!dsram_bready);
				@(posedge clock);
				#0.5 dsram_bvalid = 1'b0;
				void'(b_q.pop_front());
			end
		end
	end

	// watchdog allows 200 cycles per operation plus reset
	initial begin
		wait (n_ops != 0);
		#((n_ops * 200 + 32) * 4);
		$display("watchdog expired before all instructions retired");
		$display("Test failed");
		$fatal(1, "timeout");
	end

endmodule

//--- vlog.f
source/lsu_defs_pkg.sv
source/dbus_pkg.sv
source/lsu_request_stage.sv
source/dbus_read_engine.sv
source/dbus_write_engine.sv
source/load_align.sv
source/lsu_top.sv
testbench/lsu_properties.sv
testbench/lsu_tb.sv
